// ==== source/dtlb_pkg.sv ====
package dtlb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipes and array size.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int LOAD_PIPES = 2;
    localparam int STORE_PIPES = 2;
    localparam int DTLB_ENTRIES = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address widths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int VADDR_W = 32;
    localparam int PADDR_W = 32;
    localparam int PAGE_OFFSET_W = 12;
    localparam int VPN_W = VADDR_W - PAGE_OFFSET_W;
    localparam int PPN_W = PADDR_W - PAGE_OFFSET_W;

    // Issue-queue slot and pipe numbering.
    localparam int SLOT_W = 3;
    localparam int PIPE_W = 1;
    localparam int WAY_W = $clog2(DTLB_ENTRIES);

    // Victim selection LFSR.
    localparam int LFSR_W = 8;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 8'hB3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [VADDR_W-1:0] vaddr_t;
    typedef logic [PADDR_W-1:0] paddr_t;
    typedef logic [VPN_W-1:0] vpn_t;
    typedef logic [PPN_W-1:0] ppn_t;
    typedef logic [WAY_W-1:0] way_t;
    typedef logic [SLOT_W-1:0] slot_t;
    typedef logic [PIPE_W-1:0] pipe_t;

    // Request origin, echoed back by the L2 TLB.
    typedef logic [1:0] source_t;
    localparam source_t SRC_NONE = 2'd0;
    localparam source_t SRC_LOAD = 2'd1;
    localparam source_t SRC_STORE = 2'd2;

    // Page permissions.
    typedef logic [1:0] perm_t;
    localparam int PERM_R = 0;
    localparam int PERM_W = 1;

endpackage

// ==== source/tlb_lookup.sv ====
module tlb_lookup (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  logic             req,
    input  logic             is_store,
    input  dtlb_pkg::vaddr_t vaddr,
    output logic             miss,
    output dtlb_pkg::paddr_t paddr,
    output logic             exception,
    input  logic             we,
    input  dtlb_pkg::way_t   widx,
    input  dtlb_pkg::vpn_t   wvpn,
    input  dtlb_pkg::ppn_t   wppn,
    input  dtlb_pkg::perm_t  wperm
);
    import dtlb_pkg::*;

    logic [DTLB_ENTRIES-1:0] valid;
    vpn_t                    vpn_q [DTLB_ENTRIES];
    ppn_t                    ppn_q [DTLB_ENTRIES];
    perm_t                   perm_q [DTLB_ENTRIES];

    vpn_t                    vpn;
    logic [DTLB_ENTRIES-1:0] hit;
    ppn_t                    hit_ppn;
    perm_t                   hit_perm;
    logic [DTLB_ENTRIES-1:0] wmatch;
    way_t                    wway;
    logic                    wr_en;

    assign vpn = vaddr[VADDR_W-1:PAGE_OFFSET_W];

    // Parallel compare, one-hot select of the matching entry.
    always_comb begin
        hit = '0;
        hit_ppn = '0;
        hit_perm = '0;
        for (int i = 0; i < DTLB_ENTRIES; i++) begin
            hit[i] = valid[i] && (vpn_q[i] == vpn);
            if (hit[i]) begin
                hit_ppn = hit_ppn | ppn_q[i];
                hit_perm = hit_perm | perm_q[i];
            end
        end
    end

    assign miss = req && !(|hit);
    assign paddr = {hit_ppn, vaddr[PAGE_OFFSET_W-1:0]};
    assign exception = req && (|hit)
                       && (is_store ? !hit_perm[PERM_W] : !hit_perm[PERM_R]);

    // A second refill of a page already present reuses its way.
    always_comb begin
        wway = widx;
        for (int i = DTLB_ENTRIES - 1; i >= 0; i--) begin
            wmatch[i] = valid[i] && (vpn_q[i] == wvpn);
            if (wmatch[i]) begin
                wway = way_t'(i);
            end
        end
    end

    assign wr_en = we && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wway] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            vpn_q[wway] <= wvpn;
            ppn_q[wway] <= wppn;
            perm_q[wway] <= wperm;
        end
    end

    // Refill reuse keeps translations unique.
    a_onehot_hit: assert property (@(posedge clk) disable iff (reset) $onehot0(hit));

endmodule

// ==== source/random_replace.sv ====
module random_replace (
    input  logic           clk,
    input  logic           reset,
    input  logic           advance,
    output dtlb_pkg::way_t way
);
    import dtlb_pkg::*;

    logic [LFSR_W-1:0] lfsr;
    logic              feedback;

    // Taps for x^8 + x^6 + x^5 + x^4 + 1.
    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else if (advance) begin
            lfsr <= {lfsr[LFSR_W-2:0], feedback};
        end
    end

    assign way = lfsr[WAY_W-1:0];

    // Stuck at zero would freeze the victim way.
    a_lfsr_nonzero: assert property (@(posedge clk) disable iff (reset) lfsr != '0);

endmodule

// ==== source/tlb_repeater.sv ====
module tlb_repeater (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              in_valid,
    input  logic              in_error,
    input  logic              in_fault,
    input  dtlb_pkg::source_t in_source,
    input  dtlb_pkg::pipe_t   in_pipe,
    input  dtlb_pkg::slot_t   in_slot,
    input  dtlb_pkg::vpn_t    in_vpn,
    input  dtlb_pkg::ppn_t    in_ppn,
    input  dtlb_pkg::perm_t   in_perm,
    output logic              out_valid,
    output logic              out_error,
    output logic              out_fault,
    output dtlb_pkg::source_t out_source,
    output dtlb_pkg::pipe_t   out_pipe,
    output dtlb_pkg::slot_t   out_slot,
    output dtlb_pkg::vpn_t    out_vpn,
    output dtlb_pkg::ppn_t    out_ppn,
    output dtlb_pkg::perm_t   out_perm
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_error <= in_error;
        out_fault <= in_fault;
        out_source <= in_source;
        out_pipe <= in_pipe;
        out_slot <= in_slot;
        out_vpn <= in_vpn;
        out_ppn <= in_ppn;
        out_perm <= in_perm;
    end

endmodule

// ==== source/miss_arbiter.sv ====
module miss_arbiter (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           flush,
    input  logic [dtlb_pkg::LOAD_PIPES-1:0]                lneed,
    input  logic [dtlb_pkg::STORE_PIPES-1:0]               sneed,
    input  dtlb_pkg::vaddr_t [dtlb_pkg::LOAD_PIPES-1:0]    laddr,
    input  dtlb_pkg::vaddr_t [dtlb_pkg::STORE_PIPES-1:0]   saddr,
    input  dtlb_pkg::slot_t [dtlb_pkg::LOAD_PIPES-1:0]     lslot,
    input  dtlb_pkg::slot_t [dtlb_pkg::STORE_PIPES-1:0]    sslot,
    output logic                                           l2_req,
    output dtlb_pkg::source_t                              l2_source,
    output dtlb_pkg::pipe_t                                l2_pipe,
    output dtlb_pkg::slot_t                                l2_slot,
    output dtlb_pkg::vaddr_t                               l2_vaddr,
    output logic [dtlb_pkg::LOAD_PIPES-1:0]                lcancel,
    output logic [dtlb_pkg::STORE_PIPES-1:0]               scancel
);
    import dtlb_pkg::*;

    logic [LOAD_PIPES-1:0]    s1_lneed;
    logic [STORE_PIPES-1:0]   s1_sneed;
    vaddr_t [LOAD_PIPES-1:0]  s1_laddr;
    vaddr_t [STORE_PIPES-1:0] s1_saddr;
    slot_t [LOAD_PIPES-1:0]   s1_lslot;
    slot_t [STORE_PIPES-1:0]  s1_sslot;

    logic                     lany;
    logic                     sany;
    pipe_t                    lwin;
    pipe_t                    swin;
    logic [LOAD_PIPES-1:0]    lwin_mask;
    logic [STORE_PIPES-1:0]   swin_mask;

    logic                     req_q;
    logic [LOAD_PIPES-1:0]    lcancel_q;
    logic [STORE_PIPES-1:0]   scancel_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 1, capture the misses of this cycle.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            s1_lneed <= '0;
            s1_sneed <= '0;
        end else begin
            s1_lneed <= lneed;
            s1_sneed <= sneed;
        end
    end

    always_ff @(posedge clk) begin
        s1_laddr <= laddr;
        s1_saddr <= saddr;
        s1_lslot <= lslot;
        s1_sslot <= sslot;
    end

    // Lowest pipe wins within a kind, stores over loads.
    always_comb begin
        lwin = '0;
        swin = '0;
        for (int i = LOAD_PIPES - 1; i >= 0; i--) begin
            if (s1_lneed[i]) begin
                lwin = pipe_t'(i);
            end
        end
        for (int i = STORE_PIPES - 1; i >= 0; i--) begin
            if (s1_sneed[i]) begin
                swin = pipe_t'(i);
            end
        end
        lany = |s1_lneed;
        sany = |s1_sneed;
        lwin_mask = '0;
        swin_mask = '0;
        if (sany) begin
            swin_mask[swin] = 1'b1;
        end else if (lany) begin
            lwin_mask[lwin] = 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 2, request toward the L2 TLB and cancels for the losers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            req_q <= 1'b0;
            lcancel_q <= '0;
            scancel_q <= '0;
        end else begin
            req_q <= lany || sany;
            lcancel_q <= s1_lneed & ~lwin_mask;
            scancel_q <= s1_sneed & ~swin_mask;
        end
    end

    always_ff @(posedge clk) begin
        l2_source <= sany ? SRC_STORE : SRC_LOAD;
        l2_pipe <= sany ? swin : lwin;
        l2_slot <= sany ? s1_sslot[swin] : s1_lslot[lwin];
        l2_vaddr <= sany ? s1_saddr[swin] : s1_laddr[lwin];
    end

    assign l2_req = req_q && !flush;
    assign lcancel = lcancel_q & {LOAD_PIPES{!flush}};
    assign scancel = scancel_q & {STORE_PIPES{!flush}};

    // The pipe that got the request is never told to replay.
    a_winner_not_cancelled: assert property (@(posedge clk) disable iff (reset)
        req_q |-> !((l2_source == SRC_LOAD) ? lcancel_q[l2_pipe] : scancel_q[l2_pipe]));

endmodule

// ==== source/dtlb.sv ====
module dtlb (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          flush,
    input  logic [dtlb_pkg::LOAD_PIPES-1:0]               lreq,
    input  dtlb_pkg::vaddr_t [dtlb_pkg::LOAD_PIPES-1:0]   laddr,
    input  dtlb_pkg::slot_t [dtlb_pkg::LOAD_PIPES-1:0]    lslot,
    output logic [dtlb_pkg::LOAD_PIPES-1:0]               lmiss,
    output dtlb_pkg::paddr_t [dtlb_pkg::LOAD_PIPES-1:0]   lpaddr,
    output logic [dtlb_pkg::LOAD_PIPES-1:0]               lexception,
    output logic [dtlb_pkg::LOAD_PIPES-1:0]               lcancel,
    output logic [dtlb_pkg::LOAD_PIPES-1:0]               lwb,
    input  logic [dtlb_pkg::STORE_PIPES-1:0]              sreq,
    input  dtlb_pkg::vaddr_t [dtlb_pkg::STORE_PIPES-1:0]  saddr,
    input  dtlb_pkg::slot_t [dtlb_pkg::STORE_PIPES-1:0]   sslot,
    output logic [dtlb_pkg::STORE_PIPES-1:0]              smiss,
    output dtlb_pkg::paddr_t [dtlb_pkg::STORE_PIPES-1:0]  spaddr,
    output logic [dtlb_pkg::STORE_PIPES-1:0]              sexception,
    output logic [dtlb_pkg::STORE_PIPES-1:0]              scancel,
    output logic [dtlb_pkg::STORE_PIPES-1:0]              swb,
    output logic                                          l2_req,
    output dtlb_pkg::source_t                             l2_source,
    output dtlb_pkg::pipe_t                               l2_pipe,
    output dtlb_pkg::slot_t                               l2_slot,
    output dtlb_pkg::vaddr_t                              l2_vaddr,
    input  logic                                          l2_valid,
    input  logic                                          l2_error,
    input  logic                                          l2_fault,
    input  dtlb_pkg::source_t                             l2_source_o,
    input  dtlb_pkg::pipe_t                               l2_pipe_o,
    input  dtlb_pkg::slot_t                               l2_slot_o,
    input  dtlb_pkg::vpn_t                                l2_vpn,
    input  dtlb_pkg::ppn_t                                l2_ppn,
    input  dtlb_pkg::perm_t                               l2_perm,
    output dtlb_pkg::slot_t                               wb_slot,
    output logic                                          wb_fault,
    output logic                                          wb_error
);
    import dtlb_pkg::*;

    // Between the two repeaters.
    logic    m_valid, m_error, m_fault;
    source_t m_source;
    pipe_t   m_pipe;
    slot_t   m_slot;
    vpn_t    m_vpn;
    ppn_t    m_ppn;
    perm_t   m_perm;

    // At the arrays.
    logic    r_valid, r_error, r_fault;
    source_t r_source;
    pipe_t   r_pipe;
    slot_t   r_slot;
    vpn_t    r_vpn;
    ppn_t    r_ppn;
    perm_t   r_perm;

    logic    refill_we;
    logic    wb_valid;
    way_t    victim;

    tlb_repeater u_rep0 (
        .clk, .reset, .flush,
        .in_valid(l2_valid), .in_error(l2_error), .in_fault(l2_fault),
        .in_source(l2_source_o), .in_pipe(l2_pipe_o), .in_slot(l2_slot_o),
        .in_vpn(l2_vpn), .in_ppn(l2_ppn), .in_perm(l2_perm),
        .out_valid(m_valid), .out_error(m_error), .out_fault(m_fault),
        .out_source(m_source), .out_pipe(m_pipe), .out_slot(m_slot),
        .out_vpn(m_vpn), .out_ppn(m_ppn), .out_perm(m_perm)
    );

    tlb_repeater u_rep1 (
        .clk, .reset, .flush,
        .in_valid(m_valid), .in_error(m_error), .in_fault(m_fault),
        .in_source(m_source), .in_pipe(m_pipe), .in_slot(m_slot),
        .in_vpn(m_vpn), .in_ppn(m_ppn), .in_perm(m_perm),
        .out_valid(r_valid), .out_error(r_error), .out_fault(r_fault),
        .out_source(r_source), .out_pipe(r_pipe), .out_slot(r_slot),
        .out_vpn(r_vpn), .out_ppn(r_ppn), .out_perm(r_perm)
    );

    // Only clean translations are cached.
    assign refill_we = r_valid && !r_error && !r_fault && (r_source != SRC_NONE);
    assign wb_valid = r_valid && !flush;

    random_replace u_replace (
        .clk, .reset,
        .advance(refill_we && !flush),
        .way(victim)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One array copy per pipe.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar i = 0; i < LOAD_PIPES; i++) begin : g_load
        tlb_lookup u_ltlb (
            .clk, .reset, .flush,
            .req(lreq[i]), .is_store(1'b0), .vaddr(laddr[i]),
            .miss(lmiss[i]), .paddr(lpaddr[i]), .exception(lexception[i]),
            .we(refill_we), .widx(victim), .wvpn(r_vpn), .wppn(r_ppn), .wperm(r_perm)
        );
    end

    for (genvar i = 0; i < STORE_PIPES; i++) begin : g_store
        tlb_lookup u_stlb (
            .clk, .reset, .flush,
            .req(sreq[i]), .is_store(1'b1), .vaddr(saddr[i]),
            .miss(smiss[i]), .paddr(spaddr[i]), .exception(sexception[i]),
            .we(refill_we), .widx(victim), .wvpn(r_vpn), .wppn(r_ppn), .wperm(r_perm)
        );
    end

    miss_arbiter u_arb (
        .clk, .reset, .flush,
        .lneed(lmiss & ~lexception), .sneed(smiss & ~sexception),
        .laddr, .saddr, .lslot, .sslot,
        .l2_req, .l2_source, .l2_pipe, .l2_slot, .l2_vaddr,
        .lcancel, .scancel
    );

    // Writeback pulse back to the requesting pipe.
    always_ff @(posedge clk) begin
        if (reset) begin
            lwb <= '0;
            swb <= '0;
        end else begin
            for (int i = 0; i < LOAD_PIPES; i++) begin
                lwb[i] <= wb_valid && (r_source == SRC_LOAD) && (r_pipe == pipe_t'(i));
            end
            for (int i = 0; i < STORE_PIPES; i++) begin
                swb[i] <= wb_valid && (r_source == SRC_STORE) && (r_pipe == pipe_t'(i));
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_slot <= r_slot;
        wb_fault <= r_fault;
        wb_error <= r_error;
    end

    // One response at a time, so one writeback kind per cycle.
    a_single_wb: assert property (@(posedge clk) disable iff (reset) !((|lwb) && (|swb)));

endmodule

// ==== testbench/dtlb_tb.sv ====
module dtlb_tb;
    import dtlb_pkg::*;

    typedef enum logic [1:0] {NO_FLUSH, FLUSH_AFTER_MISS, FLUSH_IN_REPEATER} flush_mode_t;

    typedef struct packed {
        logic        is_store;
        pipe_t       pipe;
        vaddr_t      vaddr;
        slot_t       slot;
        flush_mode_t flush_mode;
        logic        exp_miss;
        logic        exp_exc;
        logic        exp_fault;
    } row_t;

    typedef struct packed {
        int      ready;
        source_t source;
        pipe_t   pipe;
        slot_t   slot;
        vpn_t    vpn;
    } l2_job_t;

    logic clk = 1'b0;
    logic reset;
    logic flush;
    logic [LOAD_PIPES-1:0] lreq, lmiss, lexception, lcancel, lwb;
    vaddr_t [LOAD_PIPES-1:0] laddr;
    slot_t [LOAD_PIPES-1:0] lslot;
    paddr_t [LOAD_PIPES-1:0] lpaddr;
    logic [STORE_PIPES-1:0] sreq, smiss, sexception, scancel, swb;
    vaddr_t [STORE_PIPES-1:0] saddr;
    slot_t [STORE_PIPES-1:0] sslot;
    paddr_t [STORE_PIPES-1:0] spaddr;
    logic l2_req;
    source_t l2_source;
    pipe_t l2_pipe;
    slot_t l2_slot;
    vaddr_t l2_vaddr;
    logic l2_valid, l2_error, l2_fault;
    source_t l2_source_o;
    pipe_t l2_pipe_o;
    slot_t l2_slot_o;
    vpn_t l2_vpn;
    ppn_t l2_ppn;
    perm_t l2_perm;
    slot_t wb_slot;
    logic wb_fault, wb_error;

    row_t rows[$];
    string row_names[$];

    dtlb i_dut (.*);

    always #10 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Second-level TLB model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic paddr_t model_paddr(vaddr_t va);
        return {va[VADDR_W-1:PAGE_OFFSET_W] ^ 20'h5A5A5, va[PAGE_OFFSET_W-1:0]};
    endfunction

    // Pages with vpn bit 0 set are read only.
    function automatic logic store_blocked(vaddr_t va);
        return va[PAGE_OFFSET_W];
    endfunction

    initial begin : l2_model
        l2_job_t jobs[$];
        l2_job_t job;
        logic [31:0] rng;
        int cycle_count;
        int last_ready;
        int delay;
        rng = 32'd49385;
        cycle_count = 0;
        last_ready = 0;
        l2_valid = 1'b0;
        l2_error = 1'b0;
        l2_fault = 1'b0;
        l2_source_o = SRC_NONE;
        l2_pipe_o = '0;
        l2_slot_o = '0;
        l2_vpn = '0;
        l2_ppn = '0;
        l2_perm = '0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (!reset && l2_req === 1'b1) begin
                rng = xorshift(rng);
                delay = 1 + int'(rng % 32'd6);
                job.ready = cycle_count + delay - 1;
                if (job.ready <= last_ready) begin
                    job.ready = last_ready + 1;
                end
                last_ready = job.ready;
                job.source = l2_source;
                job.pipe = l2_pipe;
                job.slot = l2_slot;
                job.vpn = l2_vaddr[VADDR_W-1:PAGE_OFFSET_W];
                jobs.push_back(job);
            end
            @(negedge clk);
            l2_valid = 1'b0;
            if (jobs.size() > 0 && jobs[0].ready <= cycle_count) begin
                job = jobs.pop_front();
                l2_valid = 1'b1;
                l2_source_o = job.source;
                l2_pipe_o = job.pipe;
                l2_slot_o = job.slot;
                l2_vpn = job.vpn;
                l2_ppn = job.vpn ^ 20'h5A5A5;
                l2_fault = (job.vpn[7:4] == 4'hF);
                l2_perm = {!job.vpn[0], 1'b1};
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            stop_with_failure("value check failed");
        end
    endtask

    task automatic add_row(string name, logic is_store, pipe_t pipe, vaddr_t vaddr,
                           slot_t slot, flush_mode_t flush_mode, logic exp_miss,
                           logic exp_exc, logic exp_fault);
        row_t r;
        r = '{is_store, pipe, vaddr, slot, flush_mode, exp_miss, exp_exc, exp_fault};
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    task automatic raise_request(logic is_store, pipe_t pipe, vaddr_t va, slot_t slot);
        if (is_store) begin
            sreq[pipe] = 1'b1;
            saddr[pipe] = va;
            sslot[pipe] = slot;
        end else begin
            lreq[pipe] = 1'b1;
            laddr[pipe] = va;
            lslot[pipe] = slot;
        end
    endtask

    // Drives at the falling edge, checks at the rising edge, ends one falling edge later.
    task automatic lookup_once(string name, logic is_store, pipe_t pipe, vaddr_t va,
                               slot_t slot, logic exp_miss, logic exp_exc);
        @(negedge clk);
        lreq = '0;
        sreq = '0;
        raise_request(is_store, pipe, va, slot);
        @(posedge clk);
        if (is_store) begin
            check({name, " miss"}, 32'(exp_miss), 32'(smiss[pipe]));
            check({name, " exception"}, 32'(exp_miss ? 1'b0 : exp_exc),
                  32'(sexception[pipe]));
            if (!exp_miss) begin
                check({name, " paddr"}, model_paddr(va), spaddr[pipe]);
            end
        end else begin
            check({name, " miss"}, 32'(exp_miss), 32'(lmiss[pipe]));
            check({name, " exception"}, 32'(exp_miss ? 1'b0 : exp_exc),
                  32'(lexception[pipe]));
            if (!exp_miss) begin
                check({name, " paddr"}, model_paddr(va), lpaddr[pipe]);
            end
        end
        @(negedge clk);
        lreq = '0;
        sreq = '0;
    endtask

    task automatic check_all_pipes(string name, vaddr_t va);
        pipe_t pp;
        @(negedge clk);
        for (int p = 0; p < 2; p++) begin
            pp = pipe_t'(p);
            raise_request(1'b0, pp, va, 3'd0);
            raise_request(1'b1, pp, va, 3'd0);
        end
        @(posedge clk);
        for (int p = 0; p < 2; p++) begin
            pp = pipe_t'(p);
            check({name, " all lmiss"}, 32'(1'b0), 32'(lmiss[pp]));
            check({name, " all lpaddr"}, model_paddr(va), lpaddr[pp]);
            check({name, " all lexception"}, 32'(1'b0), 32'(lexception[pp]));
            check({name, " all smiss"}, 32'(1'b0), 32'(smiss[pp]));
            check({name, " all spaddr"}, model_paddr(va), spaddr[pp]);
            check({name, " all sexception"}, 32'(store_blocked(va)), 32'(sexception[pp]));
        end
        @(negedge clk);
        lreq = '0;
        sreq = '0;
    endtask

    // Called one falling edge after the miss cycle T; checks T+1 and T+2.
    task automatic expect_request(string name, logic is_store, pipe_t pipe, vaddr_t va,
                                  slot_t slot);
        @(posedge clk);
        check({name, " early l2_req"}, 32'(1'b0), 32'(l2_req));
        @(posedge clk);
        check({name, " l2_req"}, 32'(1'b1), 32'(l2_req));
        check({name, " l2_source"}, 32'(is_store ? SRC_STORE : SRC_LOAD), 32'(l2_source));
        check({name, " l2_pipe"}, 32'(pipe), 32'(l2_pipe));
        check({name, " l2_slot"}, 32'(slot), 32'(l2_slot));
        check({name, " l2_vaddr"}, va, l2_vaddr);
    endtask

    task automatic wait_writeback(string name, logic is_store, pipe_t pipe, slot_t slot,
                                  logic exp_fault);
        logic found;
        int waited;
        found = 1'b0;
        waited = 0;
        while (!found && waited < 50) begin
            @(posedge clk);
            waited++;
            found = is_store ? swb[pipe] : lwb[pipe];
        end
        if (!found) begin
            stop_with_failure({name, ": writeback pulse never came"});
        end
        check({name, " wb_slot"}, 32'(slot), 32'(wb_slot));
        check({name, " wb_fault"}, 32'(exp_fault), 32'(wb_fault));
        check({name, " wb_error"}, 32'(1'b0), 32'(wb_error));
    endtask

    task automatic quiet_window(string name, int cycles);
        repeat (cycles) begin
            @(posedge clk);
            check({name, " quiet l2_req"}, 32'(1'b0), 32'(l2_req));
            check({name, " quiet lcancel"}, 32'(2'b00), 32'(lcancel));
            check({name, " quiet scancel"}, 32'(2'b00), 32'(scancel));
            check({name, " quiet lwb"}, 32'(2'b00), 32'(lwb));
            check({name, " quiet swb"}, 32'(2'b00), 32'(swb));
        end
    endtask

    // A miss that is killed by a flush in the next cycle.
    task automatic kill_miss(string name, logic is_store, pipe_t pipe, vaddr_t va,
                             slot_t slot);
        lookup_once(name, is_store, pipe, va, slot, 1'b1, 1'b0);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        quiet_window(name, 10);
    endtask

    task automatic run_row(string name, row_t r);
        logic found;
        int waited;
        lookup_once(name, r.is_store, r.pipe, r.vaddr, r.slot, r.exp_miss, r.exp_exc);
        if (r.exp_miss && r.flush_mode == FLUSH_AFTER_MISS) begin
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            quiet_window(name, 12);
        end else if (r.exp_miss && r.flush_mode == FLUSH_IN_REPEATER) begin
            expect_request(name, r.is_store, r.pipe, r.vaddr, r.slot);
            found = 1'b0;
            waited = 0;
            while (!found && waited < 50) begin
                @(posedge clk);
                waited++;
                found = l2_valid;
            end
            if (!found) begin
                stop_with_failure({name, ": second-level response never came"});
            end
            @(negedge clk);
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            quiet_window(name, 8);
            kill_miss({name, " again"}, r.is_store, r.pipe, r.vaddr, r.slot);
        end else if (r.exp_miss) begin
            expect_request(name, r.is_store, r.pipe, r.vaddr, r.slot);
            wait_writeback(name, r.is_store, r.pipe, r.slot, r.exp_fault);
            if (r.exp_fault) begin
                kill_miss({name, " again"}, r.is_store, r.pipe, r.vaddr, r.slot);
            end else begin
                lookup_once({name, " hit"}, r.is_store, r.pipe, r.vaddr, r.slot, 1'b0,
                            r.exp_exc);
                check_all_pipes(name, r.vaddr);
            end
        end
    endtask

    // Two misses in one cycle; stores win over loads, then the lower pipe.
    task automatic race(string name, logic a_store, pipe_t a_pipe, vaddr_t a_va,
                        logic b_store, pipe_t b_pipe, vaddr_t b_va);
        logic a_wins;
        logic w_store;
        pipe_t w_pipe;
        vaddr_t w_va;
        slot_t w_slot;
        logic [1:0] exp_lcancel;
        logic [1:0] exp_scancel;
        a_wins = (a_store && !b_store) || (a_store == b_store && a_pipe < b_pipe);
        w_store = a_wins ? a_store : b_store;
        w_pipe = a_wins ? a_pipe : b_pipe;
        w_va = a_wins ? a_va : b_va;
        w_slot = a_wins ? 3'd5 : 3'd6;
        exp_lcancel = '0;
        exp_scancel = '0;
        if (a_wins && b_store) exp_scancel[b_pipe] = 1'b1;
        if (a_wins && !b_store) exp_lcancel[b_pipe] = 1'b1;
        if (!a_wins && a_store) exp_scancel[a_pipe] = 1'b1;
        if (!a_wins && !a_store) exp_lcancel[a_pipe] = 1'b1;
        @(negedge clk);
        raise_request(a_store, a_pipe, a_va, 3'd5);
        raise_request(b_store, b_pipe, b_va, 3'd6);
        @(posedge clk);
        check({name, " a miss"}, 32'(1'b1), 32'(a_store ? smiss[a_pipe] : lmiss[a_pipe]));
        check({name, " b miss"}, 32'(1'b1), 32'(b_store ? smiss[b_pipe] : lmiss[b_pipe]));
        @(negedge clk);
        lreq = '0;
        sreq = '0;
        @(posedge clk);
        check({name, " early lcancel"}, 32'(2'b00), 32'(lcancel));
        check({name, " early scancel"}, 32'(2'b00), 32'(scancel));
        check({name, " early l2_req"}, 32'(1'b0), 32'(l2_req));
        @(posedge clk);
        check({name, " l2_req"}, 32'(1'b1), 32'(l2_req));
        check({name, " l2_source"}, 32'(w_store ? SRC_STORE : SRC_LOAD), 32'(l2_source));
        check({name, " l2_pipe"}, 32'(w_pipe), 32'(l2_pipe));
        check({name, " l2_vaddr"}, w_va, l2_vaddr);
        check({name, " lcancel"}, 32'(exp_lcancel), 32'(lcancel));
        check({name, " scancel"}, 32'(exp_scancel), 32'(scancel));
        wait_writeback(name, w_store, w_pipe, w_slot, 1'b0);
        lookup_once({name, " hit"}, w_store, w_pipe, w_va, w_slot, 1'b0, 1'b0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        reset = 1'b1;
        flush = 1'b0;
        lreq = '0;
        sreq = '0;
        laddr = '0;
        saddr = '0;
        lslot = '0;
        sslot = '0;

        // Name, store, pipe, vaddr, slot, flush, miss, exception, fault.
        add_row("load_first", 1'b0, 1'b0, 32'h0001_2345, 3'd1, NO_FLUSH, 1'b1, 1'b0, 1'b0);
        add_row("store_hit_rw", 1'b1, 1'b1, 32'h0001_2ABC, 3'd2, NO_FLUSH, 1'b0, 1'b0, 1'b0);
        add_row("load_ro_page", 1'b0, 1'b1, 32'h0002_3010, 3'd3, NO_FLUSH, 1'b1, 1'b0, 1'b0);
        add_row("store_ro_page", 1'b1, 1'b1, 32'h0002_3018, 3'd4, NO_FLUSH, 1'b0, 1'b1, 1'b0);
        add_row("store_first", 1'b1, 1'b0, 32'h0003_4800, 3'd0, NO_FLUSH, 1'b1, 1'b0, 1'b0);
        add_row("load_fault", 1'b0, 1'b0, 32'h000F_4000, 3'd5, NO_FLUSH, 1'b1, 1'b0, 1'b1);
        add_row("store_fault", 1'b1, 1'b1, 32'h001F_0FFC, 3'd6, NO_FLUSH, 1'b1, 1'b0, 1'b1);
        add_row("flush_after_miss", 1'b0, 1'b1, 32'h0030_0040, 3'd7, FLUSH_AFTER_MISS,
                1'b1, 1'b0, 1'b0);
        add_row("flush_in_repeater", 1'b1, 1'b0, 32'h0041_0100, 3'd2, FLUSH_IN_REPEATER,
                1'b1, 1'b0, 1'b0);
        // More pages than entries.
        for (int i = 0; i < 10; i++) begin
            add_row($sformatf("fill_%0d", i), i[0], pipe_t'(i >> 1),
                    {vpn_t'(32'h0200_0 + 2 * i), 12'h0A8}, slot_t'(i), NO_FLUSH,
                    1'b1, 1'b0, 1'b0);
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        quiet_window("after_reset", 2);

        for (int i = 0; i < rows.size(); i++) begin
            run_row(row_names[i], rows[i]);
        end

        race("load_vs_store", 1'b0, 1'b0, 32'h0300_0010, 1'b1, 1'b1, 32'h0300_2020);
        race("two_loads", 1'b0, 1'b1, 32'h0300_4030, 1'b0, 1'b0, 32'h0300_6040);

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== all.f ====
source/dtlb_pkg.sv
source/tlb_lookup.sv
source/random_replace.sv
source/tlb_repeater.sv
source/miss_arbiter.sv
source/dtlb.sv
testbench/dtlb_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module dtlb_tb -f all.f -o dtlb_sim || exit 1
out=$(./obj_dir/dtlb_sim)
echo "$out"
echo "$out" | grep -q "Everything OK" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
